// File: verilog/rename_defines.svh
/* Vector rename sizing */

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural vector registers v0..v31
`define RN_NUM_VREGS  32

// Physical vector registers, the upper half starts out free
`define RN_NUM_PHREGS 64

// Map versions, one of them is always the live map
`define RN_NUM_CKPT   4

// Writeback ports that can mark registers ready per cycle
`define RN_NUM_WB     2

`endif

// File: verilog/rename_pkg.sv
/* Vector rename types */

`include "rename_defines.svh"

package rename_pkg;

    typedef logic [$clog2(`RN_NUM_VREGS)-1:0]  vreg_t;     // Architectural index
    typedef logic [$clog2(`RN_NUM_PHREGS)-1:0] phreg_t;    // Physical index
    typedef logic [$clog2(`RN_NUM_CKPT)-1:0]   ckpt_ptr_t; // Checkpoint label

    typedef struct packed {
        vreg_t src1;
        vreg_t src2;
        vreg_t dst;
        logic  use_vs1;
        logic  use_vs2;
        logic  use_mask;   // Reads v0 as mask
        logic  write_dst;
        logic  do_ckpt;    // Checkpoint after this rename
    } rename_req_t;

    typedef struct packed {
        phreg_t    src1;
        phreg_t    src2;
        phreg_t    srcm;     // Mapping of v0
        phreg_t    old_dst;
        phreg_t    new_dst;
        logic      rdy1;
        logic      rdy2;
        logic      rdym;
        ckpt_ptr_t ckpt;
    } rename_rsp_t;

    typedef struct packed {
        logic   valid;
        vreg_t  vreg;
        phreg_t phreg;
    } wb_t;

    typedef struct packed {
        logic   valid;
        logic   write_dst;
        vreg_t  dst;
        phreg_t new_dst;   // Becomes the committed mapping
        phreg_t old_dst;   // Goes back to the free list
    } commit_t;

endpackage

// File: verilog/vreg_free_list.sv
/* Physical vector register free list */

`timescale 1ns/1ps
`include "rename_defines.svh"

module vreg_free_list (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  alloc_i,        // Pop the head entry
    input  logic                  ckpt_en_i,
    input  rename_pkg::commit_t   commit_i,
    input  logic                  recover_i,
    input  logic                  exception_i,
    input  rename_pkg::ckpt_ptr_t recover_ckpt_i,
    output rename_pkg::phreg_t    free_reg_o,
    output logic                  empty_o
);
    import rename_pkg::*;

    localparam int fl_depth = `RN_NUM_PHREGS - `RN_NUM_VREGS;
    localparam int ptr_w    = $clog2(fl_depth);

    typedef logic [ptr_w:0] ptr_t; // MSB is the wrap bit

    phreg_t    fifo_q [fl_depth];
    ptr_t      head_q;
    ptr_t      tail_q;
    ptr_t      commit_head_q;      // Head as seen by retired instructions
    ptr_t      ckpt_head_q [`RN_NUM_CKPT];
    ckpt_ptr_t version_q;          // Tracks the map table version head
    ptr_t      head_alloc;
    ptr_t      commit_head_d;
    ptr_t      count;
    logic      push;

    // Retired writer hands back the register it replaced
    assign push = commit_i.valid & commit_i.write_dst;

    assign count         = tail_q - head_q;
    assign empty_o       = (count == '0);
    assign free_reg_o    = fifo_q[head_q[ptr_w-1:0]];
    assign head_alloc    = head_q + ptr_t'(alloc_i);
    assign commit_head_d = commit_head_q + ptr_t'(push); // One pop per retired writer

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Upper half of the physical file starts free, in order
            for (int i = 0; i < fl_depth; i++) begin
                fifo_q[i] <= phreg_t'(`RN_NUM_VREGS + i);
            end
            for (int c = 0; c < `RN_NUM_CKPT; c++) begin
                ckpt_head_q[c] <= '0;
            end
            head_q        <= '0;
            tail_q        <= ptr_t'(fl_depth); // Full
            commit_head_q <= '0;
            version_q     <= '0;
        end else begin
            // Tail always sits on the committed head slot, so the push never
            // lands on a live speculative entry
            if (push) begin
                fifo_q[tail_q[ptr_w-1:0]] <= commit_i.old_dst;
                tail_q                    <= tail_q + 1'b1;
            end
            commit_head_q <= commit_head_d;

            if (exception_i) begin
                head_q    <= commit_head_d; // Squash all speculative pops
                version_q <= '0;
            end else if (recover_i) begin
                head_q    <= ckpt_head_q[recover_ckpt_i];
                version_q <= recover_ckpt_i;
            end else begin
                head_q <= head_alloc;
                // Saved head already includes this cycle's allocation
                if (ckpt_en_i) begin
                    ckpt_head_q[version_q] <= head_alloc;
                    version_q              <= version_q + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/vreg_map_table.sv
/* Checkpointed vector map table */

`timescale 1ns/1ps
`include "rename_defines.svh"

module vreg_map_table (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  rename_pkg::rename_req_t req_i,
    input  logic                    rename_en_i,
    input  logic                    ckpt_en_i,
    input  rename_pkg::phreg_t      new_dst_i,
    input  rename_pkg::wb_t         [`RN_NUM_WB-1:0] wb_i,
    input  rename_pkg::commit_t     commit_i,
    input  logic                    recover_i,
    input  logic                    delete_ckpt_i,
    input  logic                    exception_i,
    input  rename_pkg::ckpt_ptr_t   recover_ckpt_i,
    output rename_pkg::rename_rsp_t lookup_o,
    output logic                    out_of_ckpt_o
);
    import rename_pkg::*;

    typedef logic [$clog2(`RN_NUM_CKPT):0] cnt_t; // One bit wider than the label

    phreg_t    map_q        [`RN_NUM_CKPT][`RN_NUM_VREGS];
    logic      rdy_q        [`RN_NUM_CKPT][`RN_NUM_VREGS];
    phreg_t    commit_map_q [`RN_NUM_VREGS];
    phreg_t    commit_map_d [`RN_NUM_VREGS];
    ckpt_ptr_t head_q;             // Live version
    ckpt_ptr_t tail_q;             // Oldest checkpoint still held
    ckpt_ptr_t head_nxt;
    ckpt_ptr_t tail_d;
    cnt_t      num_ckpt_q;
    logic      wr_en;
    logic      hit1;
    logic      hit2;
    logic      hitm;
    logic      [`RN_NUM_VREGS-1:0] rdy_set [`RN_NUM_CKPT];

    assign wr_en    = rename_en_i & req_i.write_dst;
    assign head_nxt = head_q + 1'b1;
    assign tail_d   = tail_q + ckpt_ptr_t'(delete_ckpt_i);

    assign out_of_ckpt_o = (num_ckpt_q == cnt_t'(`RN_NUM_CKPT - 1));

    // Committed map including a commit in this same cycle
    always_comb begin
        commit_map_d = commit_map_q;
        if (commit_i.valid && commit_i.write_dst) begin
            commit_map_d[commit_i.dst] = commit_i.new_dst;
        end
    end

    // Same-cycle writeback bypass for the lookup
    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        hitm = 1'b0;
        for (int i = 0; i < `RN_NUM_WB; i++) begin
            hit1 = hit1 | (wb_i[i].valid & (wb_i[i].vreg == req_i.src1)
                         & (wb_i[i].phreg == map_q[head_q][req_i.src1]));
            hit2 = hit2 | (wb_i[i].valid & (wb_i[i].vreg == req_i.src2)
                         & (wb_i[i].phreg == map_q[head_q][req_i.src2]));
            hitm = hitm | (wb_i[i].valid & (wb_i[i].vreg == '0)
                         & (wb_i[i].phreg == map_q[head_q][0]));
        end
    end

    always_comb begin
        lookup_o.src1    = map_q[head_q][req_i.src1];
        lookup_o.src2    = map_q[head_q][req_i.src2];
        lookup_o.srcm    = map_q[head_q][0];           // Mask is always v0
        lookup_o.old_dst = map_q[head_q][req_i.dst];
        lookup_o.new_dst = '0;                          // Filled by the control
        lookup_o.rdy1    = rdy_q[head_q][req_i.src1] | hit1 | ~req_i.use_vs1;
        lookup_o.rdy2    = rdy_q[head_q][req_i.src2] | hit2 | ~req_i.use_vs2;
        lookup_o.rdym    = rdy_q[head_q][0] | hitm | ~req_i.use_mask;
        lookup_o.ckpt    = head_q;  // Label that holds the post-rename map
    end

    // Ready bits to set per version
    // A fresh checkpoint copy is matched against the live version it came from
    always_comb begin
        ckpt_ptr_t src_v;
        for (int v = 0; v < `RN_NUM_CKPT; v++) begin
            src_v      = (ckpt_en_i && ckpt_ptr_t'(v) == head_nxt) ? head_q : ckpt_ptr_t'(v);
            rdy_set[v] = '0;
            for (int i = 0; i < `RN_NUM_WB; i++) begin
                if (wb_i[i].valid && map_q[src_v][wb_i[i].vreg] == wb_i[i].phreg) begin
                    rdy_set[v][wb_i[i].vreg] = 1'b1;
                end
            end
            // Rename to a new phreg wins over a writeback of the old one
            if (wr_en && (ckpt_ptr_t'(v) == head_q
                          || (ckpt_en_i && ckpt_ptr_t'(v) == head_nxt))) begin
                rdy_set[v][req_i.dst] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int v = 0; v < `RN_NUM_CKPT; v++) begin
                for (int j = 0; j < `RN_NUM_VREGS; j++) begin
                    map_q[v][j] <= phreg_t'(j); // Identity map
                    rdy_q[v][j] <= 1'b1;
                end
            end
            for (int j = 0; j < `RN_NUM_VREGS; j++) begin
                commit_map_q[j] <= phreg_t'(j);
            end
            head_q     <= '0;
            tail_q     <= '0;
            num_ckpt_q <= '0;
        end else if (exception_i) begin
            // Back to the architectural state, all values exist in the file
            for (int j = 0; j < `RN_NUM_VREGS; j++) begin
                map_q[0][j] <= commit_map_d[j];
                rdy_q[0][j] <= 1'b1;
            end
            commit_map_q <= commit_map_d;
            head_q       <= '0;
            tail_q       <= '0;
            num_ckpt_q   <= '0;
        end else begin
            commit_map_q <= commit_map_d;
            tail_q       <= tail_d;

            if (recover_i) begin
                head_q     <= recover_ckpt_i;
                num_ckpt_q <= cnt_t'(ckpt_ptr_t'(recover_ckpt_i - tail_d)); // Wraps mod 4
            end else begin
                num_ckpt_q <= num_ckpt_q + cnt_t'(ckpt_en_i) - cnt_t'(delete_ckpt_i);
                if (ckpt_en_i) begin
                    for (int j = 0; j < `RN_NUM_VREGS; j++) begin
                        map_q[head_nxt][j] <= map_q[head_q][j];
                        rdy_q[head_nxt][j] <= rdy_q[head_q][j];
                    end
                    head_q <= head_nxt;
                end
                // Destination lands in the checkpoint and in the new live copy
                if (wr_en) begin
                    map_q[head_q][req_i.dst] <= new_dst_i;
                    rdy_q[head_q][req_i.dst] <= 1'b0;
                    if (ckpt_en_i) begin
                        map_q[head_nxt][req_i.dst] <= new_dst_i;
                        rdy_q[head_nxt][req_i.dst] <= 1'b0;
                    end
                end
            end

            for (int v = 0; v < `RN_NUM_CKPT; v++) begin
                for (int j = 0; j < `RN_NUM_VREGS; j++) begin
                    if (rdy_set[v][j]) begin
                        rdy_q[v][j] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: verilog/rename_ctrl.sv
/* Rename handshake control */

`timescale 1ns/1ps

module rename_ctrl (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    req_valid_i,
    input  rename_pkg::rename_req_t req_i,
    output logic                    req_ready_o,
    output logic                    rsp_valid_o,
    output rename_pkg::rename_rsp_t rsp_o,
    input  logic                    rsp_ready_i,
    input  rename_pkg::rename_rsp_t lookup_i,
    input  rename_pkg::phreg_t      free_reg_i,
    input  logic                    empty_i,
    input  logic                    out_of_ckpt_i,
    input  logic                    recover_i,
    input  logic                    exception_i,
    output logic                    alloc_o,
    output logic                    rename_en_o,
    output logic                    ckpt_en_o
);
    import rename_pkg::*;

    logic        rsp_valid_q;
    rename_rsp_t rsp_q;
    rename_rsp_t rsp_d;
    logic        slot_free;
    logic        dst_ok;
    logic        ckpt_ok;
    logic        flush;
    logic        accept;

    assign flush     = recover_i | exception_i;
    assign slot_free = ~rsp_valid_q | rsp_ready_i;       // Output slot drains this cycle
    assign dst_ok    = ~req_i.write_dst | ~empty_i;
    assign ckpt_ok   = ~req_i.do_ckpt | ~out_of_ckpt_i;

    // Stall rule, no rename during any recovery
    assign req_ready_o = slot_free & dst_ok & ckpt_ok & ~flush;
    assign accept      = req_valid_i & req_ready_o;

    assign alloc_o     = accept & req_i.write_dst;
    assign rename_en_o = accept;
    assign ckpt_en_o   = accept & req_i.do_ckpt;

    always_comb begin
        rsp_d         = lookup_i;
        rsp_d.new_dst = req_i.write_dst ? free_reg_i : '0;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_valid_q <= 1'b0;
        end else if (flush) begin
            rsp_valid_q <= 1'b0;   // Response belongs to a squashed path
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Payload only moves on accept, so it holds under back-pressure
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

// File: verilog/vector_rename.sv
/* Vector rename stage */

`timescale 1ns/1ps
`include "rename_defines.svh"

module vector_rename (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  rename_pkg::rename_req_t req_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output rename_pkg::rename_rsp_t rsp_o,
    input  rename_pkg::wb_t         [`RN_NUM_WB-1:0] wb_i,
    input  rename_pkg::commit_t     commit_i,
    input  logic                    recover_i,
    input  rename_pkg::ckpt_ptr_t   recover_ckpt_i,
    input  logic                    delete_ckpt_i,
    input  logic                    exception_i
);
    import rename_pkg::*;

    rename_rsp_t lookup;
    phreg_t      free_reg;
    logic        empty;
    logic        out_of_ckpt;
    logic        alloc;
    logic        rename_en;
    logic        ckpt_en;

    rename_ctrl i_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o),
        .rsp_ready_i   (rsp_ready_i),
        .lookup_i      (lookup),
        .free_reg_i    (free_reg),
        .empty_i       (empty),
        .out_of_ckpt_i (out_of_ckpt),
        .recover_i     (recover_i),
        .exception_i   (exception_i),
        .alloc_o       (alloc),
        .rename_en_o   (rename_en),
        .ckpt_en_o     (ckpt_en)
    );

    vreg_map_table i_map (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (req_i),
        .rename_en_i    (rename_en),
        .ckpt_en_i      (ckpt_en),
        .new_dst_i      (free_reg),   // Head of the free list
        .wb_i           (wb_i),
        .commit_i       (commit_i),
        .recover_i      (recover_i),
        .delete_ckpt_i  (delete_ckpt_i),
        .exception_i    (exception_i),
        .recover_ckpt_i (recover_ckpt_i),
        .lookup_o       (lookup),
        .out_of_ckpt_o  (out_of_ckpt)
    );

    vreg_free_list i_free (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .alloc_i        (alloc),
        .ckpt_en_i      (ckpt_en),
        .commit_i       (commit_i),
        .recover_i      (recover_i),
        .exception_i    (exception_i),
        .recover_ckpt_i (recover_ckpt_i),
        .free_reg_o     (free_reg),
        .empty_o        (empty)
    );

endmodule

// File: bench/rename_checker.sv
/* Rename response checker */

`timescale 1ns/1ps

module rename_checker (
    input  logic                    clk_i,
    input  logic                    rsp_valid_i,
    input  logic                    rsp_ready_i,
    input  rename_pkg::rename_rsp_t rsp_i
);
    import rename_pkg::*;

    rename_rsp_t exp_q [$];   // Filled by the testbench in request order
    int          errors = 0;
    int          checks = 0;

    task automatic push_expect(input rename_rsp_t r);
        exp_q.push_back(r);
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    // Failure seen outside the response compare
    task automatic report_error(input string msg);
        $display("%s at %0t", msg, $time);
        errors++;
    endtask

    task automatic compare_field(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: field %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // Inputs settle 1 ns after the edge, so mid-cycle is safe
    always @(negedge clk_i) begin
        rename_rsp_t e;
        if (rsp_valid_i && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived at %0t while no response was expected", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                compare_field("src1", rsp_i.src1, e.src1);
                compare_field("src2", rsp_i.src2, e.src2);
                compare_field("srcm", rsp_i.srcm, e.srcm);
                compare_field("old_dst", rsp_i.old_dst, e.old_dst);
                compare_field("new_dst", rsp_i.new_dst, e.new_dst);
                compare_field("rdy1", rsp_i.rdy1, e.rdy1);
                compare_field("rdy2", rsp_i.rdy2, e.rdy2);
                compare_field("rdym", rsp_i.rdym, e.rdym);
                compare_field("ckpt", rsp_i.ckpt, e.ckpt);
            end
        end
    end

endmodule

// File: bench/rename_assertions.sv
/* Rename protocol assertions */

`timescale 1ns/1ps

module rename_assertions (
    input logic                    clk_i,
    input logic                    rstn_i,
    input logic                    req_valid_i,
    input logic                    req_ready_o,
    input logic                    rsp_valid_o,
    input logic                    rsp_ready_i,
    input rename_pkg::rename_rsp_t rsp_o,
    input logic                    recover_i,
    input logic                    exception_i
);

    int fail_count = 0;   // Failed assertions, part of the run summary

    // Stalled response keeps its payload
    rsp_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> $stable(rsp_o))
        else begin
            $error("Response changed while stalled");
            fail_count++;
        end

    rsp_idle_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !rsp_valid_o)
        else begin
            $error("Response valid during reset");
            fail_count++;
        end

    // No rename during any flush
    no_accept_on_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (recover_i || exception_i) |-> !(req_valid_i && req_ready_o))
        else begin
            $error("Request accepted during recover or exception");
            fail_count++;
        end

endmodule

bind vector_rename rename_assertions i_asrt (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .recover_i   (recover_i),
    .exception_i (exception_i)
);

// File: bench/rename_tb.sv
/* Vector rename testbench */

`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int wait_limit = 64;   // Cycles per bounded wait

    logic                         clk_i;
    logic                         rstn_i;
    logic                         req_valid_i;
    logic                         req_ready_o;
    rename_req_t                  req_i;
    logic                         rsp_valid_o;
    logic                         rsp_ready_i;
    rename_rsp_t                  rsp_o;
    wb_t [`RN_NUM_WB-1:0]         wb_i;
    commit_t                      commit_i;
    logic                         recover_i;
    ckpt_ptr_t                    recover_ckpt_i;
    logic                         delete_ckpt_i;
    logic                         exception_i;

    int          stall_left = 0;   // Cycles left with rsp_ready_i low
    int          del_left   = 0;   // Cycles until delete_ckpt_i pulses
    logic        timed_out  = 1'b0;
    logic [31:0] rnd        = 32'h45abe4ca;

    vector_rename i_dut (.*);

    rename_checker i_checker (
        .clk_i       (clk_i),
        .rsp_valid_i (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_i       (rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Advance one cycle; stall and delete timers run here
    task automatic step();
        @(posedge clk_i);
        #1;
        if (delete_ckpt_i) delete_ckpt_i = 1'b0;
        if (del_left > 0) begin
            del_left--;
            if (del_left == 0) delete_ckpt_i = 1'b1;
        end
        if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) rsp_ready_i = 1'b1;
        end
    endtask

    task automatic do_rename(input rename_req_t rq, input wb_t w, input rename_rsp_t ex);
        int   waited;
        logic took;
        waited = 0;
        took   = 1'b0;
        i_checker.push_expect(ex);
        req_i       = rq;
        req_valid_i = 1'b1;
        wb_i[0]     = w;       // Repeats while stalled, harmless
        while (!took && !timed_out) begin
            @(negedge clk_i);
            took = req_ready_o;
            // Checkpoint request must hold off until the pending delete went through
            if (took && rq.do_ckpt && del_left > 0) begin
                i_checker.report_error("Checkpoint request accepted before the delete");
            end
            step();
            waited++;
            if (!took && waited >= wait_limit) begin
                $display("Rename request was not accepted within %0d cycles", wait_limit);
                timed_out = 1'b1;
            end
        end
        req_valid_i = 1'b0;
        wb_i        = '0;
    endtask

    // Wait until every expected response was seen
    task automatic drain();
        int waited;
        waited = 0;
        while (i_checker.outstanding() > 0 && !timed_out) begin
            step();
            waited++;
            if (waited >= wait_limit) begin
                $display("Expected responses did not arrive within %0d cycles", wait_limit);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic end_test(input string name, input int c0, input int e0);
        drain();
        $display("Test %s: %0d checks, %0d errors", name,
                 i_checker.checks - c0, i_checker.errors - e0);
    endtask

    initial begin
        int          fd;
        int          ntests;
        int          c0;
        int          e0;
        int          f [20];
        byte         opc;
        string       line;
        string       tname;
        rename_req_t rq;
        rename_rsp_t ex;
        wb_t         w;

        rstn_i         = 1'b0;
        req_valid_i    = 1'b0;
        req_i          = '0;
        rsp_ready_i    = 1'b1;
        wb_i           = '0;
        commit_i       = '0;
        recover_i      = 1'b0;
        recover_ckpt_i = '0;
        delete_ckpt_i  = 1'b0;
        exception_i    = 1'b0;
        ntests         = 0;
        tname          = "";
        repeat (5) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        step();

        fd = $fopen("bench/rename_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            timed_out = 1'b1;
        end
        while (!timed_out && fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0) continue;
            opc = line[0];
            case (opc)
                "T": begin
                    if (tname != "") end_test(tname, c0, e0);
                    void'($sscanf(line, "%c %s", opc, tname));
                    c0 = i_checker.checks;
                    e0 = i_checker.errors;
                    ntests++;
                end
                "R": begin
                    void'($sscanf(line,
                        "%c %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        opc, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19]));
                    rq.src1      = f[0];
                    rq.src2      = f[1];
                    rq.dst       = f[2];
                    rq.use_vs1   = f[3];
                    rq.use_vs2   = f[4];
                    rq.use_mask  = f[5];
                    rq.write_dst = f[6];
                    rq.do_ckpt   = f[7];
                    w.valid      = f[8];
                    w.vreg       = f[9];
                    w.phreg      = f[10];
                    ex.src1      = f[11];
                    ex.src2      = f[12];
                    ex.srcm      = f[13];
                    ex.old_dst   = f[14];
                    ex.new_dst   = f[15];
                    ex.rdy1      = f[16];
                    ex.rdy2      = f[17];
                    ex.rdym      = f[18];
                    ex.ckpt      = f[19];
                    do_rename(rq, w, ex);
                end
                "F": begin
                    // Run of plain writers, phregs leave the list in order
                    void'($sscanf(line, "%c %d %d %d %d", opc, f[0], f[1], f[2], f[3]));
                    for (int k = 0; k < f[0] && !timed_out; k++) begin
                        rq = '0;
                        rq.dst = f[1];
                        rq.write_dst = 1'b1;
                        ex = '0;
                        ex.old_dst = (k == 0) ? f[2] : f[3] + k - 1;
                        ex.new_dst = f[3] + k;
                        ex.rdy1 = 1'b1;
                        ex.rdy2 = 1'b1;
                        ex.rdym = 1'b1;
                        do_rename(rq, '0, ex);
                    end
                end
                "W": begin
                    void'($sscanf(line, "%c %d %d", opc, f[0], f[1]));
                    wb_i[0] = '{valid: 1'b1, vreg: f[0], phreg: f[1]};
                    step();
                    wb_i = '0;
                end
                "C": begin
                    void'($sscanf(line, "%c %d %d %d %d", opc, f[0], f[1], f[2], f[3]));
                    commit_i = '{valid: 1'b1, write_dst: f[0], dst: f[1],
                                 new_dst: f[2], old_dst: f[3]};
                    step();
                    commit_i = '0;
                end
                "V": begin
                    void'($sscanf(line, "%c %d", opc, f[0]));
                    recover_i      = 1'b1;
                    recover_ckpt_i = f[0];
                    req_valid_i    = 1'b1;   // Last request offered, must not be taken
                    step();
                    recover_i   = 1'b0;
                    req_valid_i = 1'b0;
                end
                "X": begin
                    exception_i = 1'b1;
                    req_valid_i = 1'b1;      // Same for the exception cycle
                    step();
                    exception_i = 1'b0;
                    req_valid_i = 1'b0;
                end
                "D": begin
                    void'($sscanf(line, "%c %d", opc, f[0]));
                    del_left = f[0];
                end
                "S": begin
                    void'($sscanf(line, "%c %d", opc, f[0]));
                    if (f[0] == 0) begin
                        rnd  = next_rand(rnd);
                        f[0] = 2 + (rnd % 4);  // Random stall of 2 to 5 cycles
                    end
                    stall_left  = f[0];
                    rsp_ready_i = 1'b0;
                end
                default: ;   // Comment or blank line
            endcase
        end
        if (fd != 0) $fclose(fd);
        if (tname != "" && !timed_out) end_test(tname, c0, e0);

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 ntests, i_checker.checks, i_checker.errors, i_dut.i_asrt.fail_count);
        if (i_checker.errors == 0 && i_dut.i_asrt.fail_count == 0 && !timed_out
            && ntests > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: bench/rename_stimulus.txt
# R s1 s2 dst vs1 vs2 vm wr ck wbv wbreg wbph  exp s1 s2 sm old new r1 r2 rm ck
# W reg ph | C wr dst new old | V ckpt | X | D cycles | S cycles (0 random) | F n dst old0 first | T name
T identity
R 3 5 7 1 1 1 0 0 0 0 0 3 5 0 7 0 1 1 1 0
R 31 0 0 1 0 1 0 0 0 0 0 31 0 0 0 0 1 1 1 0
T allocation
R 1 2 4 1 1 0 1 0 0 0 0 1 2 0 4 32 1 1 1 0
R 3 3 5 1 1 0 1 0 0 0 0 3 3 0 5 33 1 1 1 0
R 4 5 6 1 1 0 1 0 0 0 0 32 33 0 6 34 0 0 1 0
T writeback
W 4 32
R 4 6 8 1 1 1 0 0 0 0 0 32 34 0 8 0 1 0 1 0
R 6 9 9 1 0 0 0 0 1 6 34 34 9 0 9 0 1 1 1 0
R 5 5 9 0 0 0 0 0 0 0 0 33 33 0 9 0 1 1 1 0
T recover
R 1 2 10 1 1 0 1 1 0 0 0 1 2 0 10 35 1 1 1 0
R 10 0 10 1 0 0 1 0 0 0 0 35 0 0 35 36 0 1 1 1
R 11 0 12 1 0 0 1 0 0 0 0 11 0 0 12 37 1 1 1 1
V 0
R 10 12 13 1 1 0 1 0 0 0 0 35 12 0 13 36 0 1 1 0
T commit_exception
C 1 4 32 4
C 1 5 33 5
C 1 6 34 6
X
R 4 5 10 1 1 1 0 0 0 0 0 32 33 0 10 0 1 1 1 0
F 29 20 20 35
R 0 0 21 0 0 0 1 0 0 0 0 0 0 0 21 4 1 1 1 0
R 0 0 22 0 0 0 1 0 0 0 0 0 0 0 22 5 1 1 1 0
T backpressure
S 0
R 1 2 3 1 1 1 0 0 0 0 0 1 2 0 3 0 1 1 1 0
R 4 5 6 1 1 1 0 0 0 0 0 32 33 0 34 0 1 1 1 0
R 20 21 22 1 1 0 0 0 0 0 0 63 4 0 5 0 0 0 1 0
T checkpoints
R 7 7 7 1 0 0 0 1 0 0 0 7 7 0 7 0 1 1 1 0
R 7 7 7 1 0 0 0 1 0 0 0 7 7 0 7 0 1 1 1 1
R 7 7 7 1 0 0 0 1 0 0 0 7 7 0 7 0 1 1 1 2
D 3
R 7 7 7 1 0 0 0 1 0 0 0 7 7 0 7 0 1 1 1 3

// File: flist.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/vreg_free_list.sv
verilog/vreg_map_table.sv
verilog/rename_ctrl.sv
verilog/vector_rename.sv
bench/rename_checker.sv
bench/rename_assertions.sv
bench/rename_tb.sv

// File: Bender.yml
package:
  name: vector_rename

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rename_pkg.sv
      - verilog/vreg_free_list.sv
      - verilog/vreg_map_table.sv
      - verilog/rename_ctrl.sv
      - verilog/vector_rename.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/rename_checker.sv
      - bench/rename_assertions.sv
      - bench/rename_tb.sv
